/* socPkg.sv */
`default_nettype none

package socPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regIdxT;

    // anything outside these operations decodes as a harmless ADDI
    typedef enum logic [3:0] {
        opAddi,
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opLui,
        opLw,
        opSw,
        opBeq,
        opBne,
        opJal
    } opT;

    typedef struct packed {
        opT     op;
        regIdxT rd;
        regIdxT rs1;
        regIdxT rs2;
        wordT   imm;
    } decodedT;

    typedef struct packed {
        wordT value;
        logic takeBranch;
        wordT nextPc;
        wordT memAddr;
        wordT storeData;
        logic writesRd;
    } execT;

    typedef struct packed {
        logic write;
        wordT addr;
        wordT wdata;
    } memReqT;

endpackage

`default_nettype wire

/* socDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module socDecode
    import socPkg::*;
(
    input  wire wordT instr,
    output decodedT   dec
);

    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcJal    = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       known;
    wordT       immI;
    wordT       immS;
    wordT       immB;
    wordT       immU;
    wordT       immJ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'h000};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec.op  = opAddi;
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.imm = immI;
        known   = 1'b1;
        case (opcode)
            opcOpImm: known = (funct3 == 3'b000);
            opcOp: begin
                case ({funct7, funct3})
                    10'b0000000_000: dec.op = opAdd;
                    10'b0100000_000: dec.op = opSub;
                    10'b0000000_111: dec.op = opAnd;
                    10'b0000000_110: dec.op = opOr;
                    10'b0000000_100: dec.op = opXor;
                    default:         known = 1'b0;
                endcase
            end
            opcLui: begin
                dec.op  = opLui;
                dec.imm = immU;
            end
            opcLoad: begin
                dec.op = opLw;
                known  = (funct3 == 3'b010);
            end
            opcStore: begin
                dec.op  = opSw;
                dec.imm = immS;
                known   = (funct3 == 3'b010);
            end
            opcBranch: begin
                dec.op  = funct3[0] ? opBne : opBeq;
                dec.imm = immB;
                known   = (funct3[2:1] == 2'b00);
            end
            opcJal: begin
                dec.op  = opJal;
                dec.imm = immJ;
            end
            default: known = 1'b0;
        endcase
        // unknown encodings turn into ADDI x0, x0, 0
        if (!known) begin
            dec.op  = opAddi;
            dec.rd  = '0;
            dec.rs1 = '0;
            dec.imm = '0;
        end
    end

endmodule

`default_nettype wire

/* socExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module socExecute
    import socPkg::*;
(
    input  wire decodedT dec,
    input  wire wordT    pc,
    input  wire wordT    rs1Val,
    input  wire wordT    rs2Val,
    output execT         ex
);

    wordT pcPlus4;
    wordT target;
    logic equal;

    assign pcPlus4 = pc + 32'd4;
    assign target  = pc + dec.imm;
    assign equal   = (rs1Val == rs2Val);

    always_comb begin
        ex.value      = rs1Val + dec.imm;
        ex.takeBranch = 1'b0;
        ex.writesRd   = 1'b1;
        ex.memAddr    = rs1Val + dec.imm;
        ex.storeData  = rs2Val;
        case (dec.op)
            opAdd: ex.value = rs1Val + rs2Val;
            opSub: ex.value = rs1Val - rs2Val;
            opAnd: ex.value = rs1Val & rs2Val;
            opOr:  ex.value = rs1Val | rs2Val;
            opXor: ex.value = rs1Val ^ rs2Val;
            opLui: ex.value = dec.imm;
            opSw:  ex.writesRd = 1'b0;
            opBeq: begin
                ex.takeBranch = equal;
                ex.writesRd   = 1'b0;
            end
            opBne: begin
                ex.takeBranch = !equal;
                ex.writesRd   = 1'b0;
            end
            // the link value goes to rd, the jump target to the pc
            opJal: begin
                ex.value      = pcPlus4;
                ex.takeBranch = 1'b1;
            end
            default: ;
        endcase
        ex.nextPc = ex.takeBranch ? target : pcPlus4;
    end

endmodule

`default_nettype wire

/* socResult.sv */
`timescale 1ns/1ps
`default_nettype none

module socResult
    import socPkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire regIdxT rs1,
    input  wire regIdxT rs2,
    output wordT        rs1Val,
    output wordT        rs2Val,
    input  wire         wbEn,
    input  wire regIdxT rd,
    input  wire wordT   wbData,
    output wordT        dumpValue
);

    // x0 has no storage, so only x1 to x31 exist
    wordT regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (rd != '0)) begin
            regs[rd] <= wbData;
        end
    end

    assign rs1Val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Val = (rs2 == '0) ? '0 : regs[rs2];

    // x10 is the result register that the dump transmitter sends
    assign dumpValue = regs[10];

endmodule

`default_nettype wire

/* socCore.sv */
`timescale 1ns/1ps
`default_nettype none

module socCore
    import socPkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       start,
    output memReqT    memReq,
    output logic      coreReq,
    input  wire       coreAck,
    input  wire wordT rdata,
    output logic      halted,
    output wordT      dumpValue
);

    typedef enum logic [2:0] {
        stIdle,
        stFetchReq,
        stFetchDone,
        stExecute,
        stMemReq,
        stMemDone,
        stWriteback,
        stHalt
    } stateT;

    stateT   state;
    wordT    pc;
    wordT    ir;
    execT    exReg;
    wordT    memData;
    decodedT dec;
    execT    ex;
    wordT    rs1Val;
    wordT    rs2Val;
    logic    wbEn;
    wordT    wbData;
    logic    isHalt;
    logic    isMem;

    socDecode decode_i (
        .instr (ir),
        .dec   (dec)
    );

    socExecute execute_i (
        .dec    (dec),
        .pc     (pc),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val),
        .ex     (ex)
    );

    socResult result_i (
        .clk       (clk),
        .rst       (rst),
        .rs1       (dec.rs1),
        .rs2       (dec.rs2),
        .rs1Val    (rs1Val),
        .rs2Val    (rs2Val),
        .wbEn      (wbEn),
        .rd        (dec.rd),
        .wbData    (wbData),
        .dumpValue (dumpValue)
    );

    // a jump to itself is the halt marker
    assign isHalt = (dec.op == opJal) && (dec.imm == '0);
    assign isMem  = (dec.op == opLw) || (dec.op == opSw);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            pc    <= '0;
        end else begin
            case (state)
                stIdle:      if (start) state <= stFetchReq;
                stFetchReq:  if (coreAck) state <= stFetchDone;
                stFetchDone: if (!coreAck) state <= stExecute;
                stExecute: begin
                    if (isHalt) begin
                        state <= stHalt;
                    end else if (isMem) begin
                        state <= stMemReq;
                    end else begin
                        state <= stWriteback;
                    end
                end
                stMemReq:    if (coreAck) state <= stMemDone;
                stMemDone:   if (!coreAck) state <= stWriteback;
                stWriteback: begin
                    pc    <= exReg.nextPc;
                    state <= stFetchReq;
                end
                stHalt:      state <= stHalt;
                default:     state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == stFetchReq) && coreAck) begin
            ir <= rdata;
        end
        if (state == stExecute) begin
            exReg <= ex;
        end
        if ((state == stMemReq) && coreAck) begin
            memData <= rdata;
        end
    end

    always_comb begin
        memReq.write = 1'b0;
        memReq.addr  = pc;
        memReq.wdata = '0;
        if (state == stMemReq) begin
            memReq.write = (dec.op == opSw);
            memReq.addr  = exReg.memAddr;
            memReq.wdata = exReg.storeData;
        end
    end

    assign coreReq = (state == stFetchReq) || (state == stMemReq);
    assign halted  = (state == stHalt);
    assign wbEn    = (state == stWriteback) && exReg.writesRd;
    assign wbData  = (dec.op == opLw) ? memData : exReg.value;

    reqStable: assert property (@(posedge clk) disable iff (rst)
        (coreReq && !coreAck) |=> $stable(memReq))
        else $error("memReq changed while waiting for coreAck");

endmodule

`default_nettype wire

/* socMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module socMemory
    import socPkg::*;
#(
    parameter int memWords = 256
) (
    input  wire         clk,
    input  wire         rst,
    input  wire memReqT memReq,
    input  wire         coreReq,
    output logic        coreAck,
    output wordT        rdata,
    input  wire         loadReq,
    input  wire wordT   loadAddr,
    input  wire wordT   loadData,
    output logic        loadAck
);

    localparam int idxW = $clog2(memWords);

    wordT            mem [memWords];
    logic [idxW-1:0] coreIdx;
    logic [idxW-1:0] loadIdx;
    logic            portsFree;
    logic            grantCore;
    logic            grantLoad;

    // the address bits above the word index simply wrap
    assign coreIdx = memReq.addr[idxW+1:2];
    assign loadIdx = loadAddr[idxW+1:2];

    assign portsFree = !coreAck && !loadAck;
    assign grantCore = portsFree && coreReq;
    assign grantLoad = portsFree && !coreReq && loadReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            coreAck <= 1'b0;
            loadAck <= 1'b0;
        end else if (coreAck) begin
            coreAck <= coreReq;
        end else if (loadAck) begin
            loadAck <= loadReq;
        end else if (grantCore) begin
            coreAck <= 1'b1;
        end else if (grantLoad) begin
            loadAck <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (grantCore && memReq.write) begin
            mem[coreIdx] <= memReq.wdata;
        end else if (grantLoad) begin
            mem[loadIdx] <= loadData;
        end
        if (grantCore) begin
            rdata <= mem[coreIdx];
        end
    end

    oneAck: assert property (@(posedge clk) disable iff (rst) !(coreAck && loadAck))
        else $error("coreAck and loadAck high together");

endmodule

`default_nettype wire

/* socUartDump.sv */
`timescale 1ns/1ps
`default_nettype none

module socUartDump
    import socPkg::*;
#(
    parameter int clksPerBit    = 234,
    parameter int holdOffCycles = 1048575
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       dumpBtn,
    input  wire wordT dumpValue,
    output logic      uartTx
);

    localparam int cntMax = (clksPerBit > holdOffCycles) ? clksPerBit : holdOffCycles;
    localparam int cntW   = $clog2(cntMax + 1);

    localparam logic [cntW-1:0] bitLast  = cntW'(clksPerBit - 1);
    localparam logic [cntW-1:0] holdLast = cntW'(holdOffCycles - 1);

    typedef enum logic [2:0] {
        txIdle,
        txStartBit,
        txDataBits,
        txStopBit,
        txHoldOff
    } txStateT;

    txStateT        state;
    logic [cntW-1:0] cnt;
    logic [2:0]      bitCnt;
    logic [2:0]      nextBit;
    logic [1:0]      byteCnt;
    logic [3:0][7:0] dumpBytes;

    assign nextBit = bitCnt + 3'd1;

    // uartTx changes on the state transition, so every bit is exactly clksPerBit long
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= txIdle;
            cnt     <= '0;
            bitCnt  <= '0;
            byteCnt <= '0;
            uartTx  <= 1'b1;
        end else begin
            case (state)
                txIdle: begin
                    uartTx <= 1'b1;
                    if (!dumpBtn) begin
                        cnt     <= '0;
                        byteCnt <= '0;
                        uartTx  <= 1'b0;
                        state   <= txStartBit;
                    end
                end
                txStartBit: begin
                    if (cnt == bitLast) begin
                        cnt    <= '0;
                        bitCnt <= '0;
                        uartTx <= dumpBytes[3][0];
                        state  <= txDataBits;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                txDataBits: begin
                    if (cnt == bitLast) begin
                        cnt <= '0;
                        if (bitCnt == 3'd7) begin
                            uartTx <= 1'b1;
                            state  <= txStopBit;
                        end else begin
                            bitCnt <= nextBit;
                            uartTx <= dumpBytes[3][nextBit];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                txStopBit: begin
                    if (cnt == bitLast) begin
                        cnt <= '0;
                        if (byteCnt == 2'd3) begin
                            state <= txHoldOff;
                        end else begin
                            byteCnt <= byteCnt + 2'd1;
                            uartTx  <= 1'b0;
                            state   <= txStartBit;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // wait out the hold-off, then for the button to be released
                txHoldOff: begin
                    if (cnt == holdLast) begin
                        if (dumpBtn) begin
                            state <= txIdle;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= txIdle;
            endcase
        end
    end

    // the byte in dumpBytes[3] is on the line and the next one shifts up after its stop bit
    always_ff @(posedge clk) begin
        if ((state == txIdle) && !dumpBtn) begin
            dumpBytes <= dumpValue;
        end else if ((state == txStopBit) && (cnt == bitLast)) begin
            dumpBytes <= {dumpBytes[2:0], 8'h00};
        end
    end

    idleHigh: assert property (@(posedge clk) disable iff (rst) (state == txIdle) |-> uartTx)
        else $error("uartTx low while the transmitter is idle");

endmodule

`default_nettype wire

/* soc.sv */
`timescale 1ns/1ps
`default_nettype none

module soc
    import socPkg::*;
#(
    parameter int memWords      = 256,
    parameter int clksPerBit    = 234,
    parameter int holdOffCycles = 1048575
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       start,
    input  wire       dumpBtn,
    input  wire       loadReq,
    input  wire wordT loadAddr,
    input  wire wordT loadData,
    output logic      loadAck,
    output logic      halted,
    output logic      uartTx
);

    memReqT memReq;
    logic   coreReq;
    logic   coreAck;
    wordT   rdata;
    wordT   dumpValue;

    socCore core_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .memReq    (memReq),
        .coreReq   (coreReq),
        .coreAck   (coreAck),
        .rdata     (rdata),
        .halted    (halted),
        .dumpValue (dumpValue)
    );

    socMemory #(
        .memWords (memWords)
    ) memory_i (
        .clk      (clk),
        .rst      (rst),
        .memReq   (memReq),
        .coreReq  (coreReq),
        .coreAck  (coreAck),
        .rdata    (rdata),
        .loadReq  (loadReq),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .loadAck  (loadAck)
    );

    socUartDump #(
        .clksPerBit    (clksPerBit),
        .holdOffCycles (holdOffCycles)
    ) uartDump_i (
        .clk       (clk),
        .rst       (rst),
        .dumpBtn   (dumpBtn),
        .dumpValue (dumpValue),
        .uartTx    (uartTx)
    );

endmodule

`default_nettype wire

/* socTb.sv */
`timescale 1ns/1ps
`default_nettype none

module socTb
    import socPkg::*;
();

    localparam int clksPerBit    = 8;
    localparam int holdOffCycles = 32;
    localparam int waitLimit     = 4000;
    localparam int runLimit      = 20000;
    localparam int quietCycles   = 100;

    localparam logic [31:0] lfsrSeed = 32'd70245;
    localparam logic [31:0] lfsrTaps = 32'h80200003;

    logic clk;
    logic rst;
    logic start;
    logic dumpBtn;
    logic loadReq;
    wordT loadAddr;
    wordT loadData;
    logic loadAck;
    logic halted;
    logic uartTx;

    int          errorCount;
    int          timeoutCount;
    logic [31:0] lfsr;

    soc #(
        .memWords      (256),
        .clksPerBit    (clksPerBit),
        .holdOffCycles (holdOffCycles)
    ) soc_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .dumpBtn  (dumpBtn),
        .loadReq  (loadReq),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .loadAck  (loadAck),
        .halted   (halted),
        .uartTx   (uartTx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ lfsrTaps;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic randomBits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsrNext(lfsr);
        end
    endtask

    task automatic randomPause();
        int cycles;
        randomBits(2, cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic waitLoadAck(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((loadAck !== level) && (n < waitLimit));
        if (loadAck !== level) begin
            timeoutCount++;
            $display("timeout: loadAck never went to %0d", level);
        end
    endtask

    task automatic resetDut();
        @(posedge clk);
        rst     <= 1'b1;
        start   <= 1'b0;
        dumpBtn <= 1'b1;
        loadReq <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("halted", halted, 1'b0);
        checkValue("uartTx", uartTx, 1'b1);
        checkValue("loadAck", loadAck, 1'b0);
    endtask

    // four-phase write through the load port
    task automatic loadWord(input wordT addr, input wordT data);
        randomPause();
        @(posedge clk);
        loadAddr <= addr;
        loadData <= data;
        loadReq  <= 1'b1;
        waitLoadAck(1'b1);
        randomPause();
        @(posedge clk);
        loadReq <= 1'b0;
        waitLoadAck(1'b0);
    endtask

    task automatic runProgram();
        int n;
        randomPause();
        @(posedge clk);
        start <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((halted !== 1'b1) && (n < runLimit));
        if (halted !== 1'b1) begin
            timeoutCount++;
            $display("timeout: the core never raised halted");
        end
        @(posedge clk);
        start <= 1'b0;
    endtask

    // bit centres are counted from the negedge right after the start bit falls
    task automatic receiveByte(output logic [7:0] data, output logic ok);
        int n;
        data = '0;
        ok   = 1'b1;
        n    = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((uartTx !== 1'b0) && (n < waitLimit));
        if (uartTx !== 1'b0) begin
            ok = 1'b0;
            timeoutCount++;
            $display("timeout: no start bit appeared on uartTx");
        end else begin
            repeat (clksPerBit / 2) @(negedge clk);
            checkValue("uartTx start bit", uartTx, 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (clksPerBit) @(negedge clk);
                data[i] = uartTx;
            end
            repeat (clksPerBit) @(negedge clk);
            checkValue("uartTx stop bit", uartTx, 1'b1);
        end
    endtask

    task automatic dumpAndCheck(input wordT expected);
        logic [7:0] rxByte;
        logic       ok;
        logic       resent;
        wordT       word;
        word   = '0;
        ok     = 1'b1;
        resent = 1'b0;
        randomPause();
        @(posedge clk);
        dumpBtn <= 1'b0;
        for (int b = 0; (b < 4) && ok; b++) begin
            receiveByte(rxByte, ok);
            word = {word[23:0], rxByte};
        end
        if (ok) begin
            checkValue("uartTx word", word, expected);
            // the button is still held, so the line has to stay idle
            for (int i = 0; i < quietCycles; i++) begin
                @(negedge clk);
                if (uartTx !== 1'b1) begin
                    resent = 1'b1;
                end
            end
            if (resent) begin
                errorCount++;
                $display("uartTx started a second dump while dumpBtn was still held");
            end
        end
        @(posedge clk);
        dumpBtn <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    initial begin
        int         fd;
        int         code;
        int         ch;
        logic [7:0] cmd;
        wordT       addr;
        wordT       data;
        logic       inProgram;
        logic       done;
        rst          = 1'b1;
        start        = 1'b0;
        dumpBtn      = 1'b1;
        loadReq      = 1'b0;
        loadAddr     = '0;
        loadData     = '0;
        errorCount   = 0;
        timeoutCount = 0;
        lfsr         = lfsrSeed;
        inProgram    = 1'b0;
        done         = 1'b0;
        fd = $fopen("socInput.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("could not open socInput.txt");
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": begin
                        do begin
                            ch = $fgetc(fd);
                        end while ((ch != 10) && (ch != -1));
                    end
                    "L": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        // the first load of a program starts it from a fresh reset
                        if (!inProgram) begin
                            resetDut();
                            inProgram = 1'b1;
                        end
                        loadWord(addr, data);
                    end
                    "R": begin
                        runProgram();
                        inProgram = 1'b0;
                    end
                    "E": begin
                        code = $fscanf(fd, "%h", data);
                        dumpAndCheck(data);
                    end
                    default: begin
                        errorCount++;
                        $display("unknown command %c in socInput.txt", cmd);
                    end
                endcase
                if (timeoutCount != 0) begin
                    done = 1'b1;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if ((errorCount == 0) && (timeoutCount == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* socInput.txt */
# L <byte address hex> <word hex> loads a word, R runs until halted
# E <x10 hex> dumps x10 over the UART and compares it, text after # is ignored
L 00 06400093  # addi x1, x0, 100
L 04 FF900113  # addi x2, x0, -7
L 08 002081B3  # add  x3, x1, x2
L 0C 40208233  # sub  x4, x1, x2
L 10 123452B7  # lui  x5, 0x12345
L 14 0032C333  # xor  x6, x5, x3
L 18 004363B3  # or   x7, x6, x4
L 1C 0023F533  # and  x10, x7, x2
L 20 0000006F  # jal  x0, 0
R
E 12345079
E 12345079
L 100 CAFEBABE # data word
L 104 01020304 # data word
L 00 10002083  # lw   x1, 0x100(x0)
L 04 05500113  # addi x2, x0, 0x55
L 08 10202423  # sw   x2, 0x108(x0)
L 0C 10802183  # lw   x3, 0x108(x0)
L 10 10400213  # addi x4, x0, 0x104
L 14 00022283  # lw   x5, 0(x4)
L 18 00122423  # sw   x1, 8(x4)
L 1C 10C02303  # lw   x6, 0x10c(x0)
L 20 005343B3  # xor  x7, x6, x5
L 24 00338533  # add  x10, x7, x3
L 28 0000006F  # jal  x0, 0
R
E CBFCBA0F
L 00 00500093  # addi x1, x0, 5
L 04 00500113  # addi x2, x0, 5
L 08 00000513  # addi x10, x0, 0
L 0C 00208463  # beq  x1, x2, +8 taken
L 10 00150513  # addi x10, x10, 1 skipped
L 14 00209463  # bne  x1, x2, +8 not taken
L 18 00250513  # addi x10, x10, 2
L 1C 008001EF  # jal  x3, +8 links 0x20
L 20 10050513  # addi x10, x10, 0x100 skipped
L 24 00350533  # add  x10, x10, x3
L 28 00050463  # beq  x10, x0, +8 not taken
L 2C 00051463  # bne  x10, x0, +8 taken
L 30 00000513  # addi x10, x0, 0 skipped
L 34 30050513  # addi x10, x10, 0x300
L 38 0000006F  # jal  x0, 0
R
E 00000322
L 00 7AB00013  # addi x0, x0, 0x7ab
L 04 000000B3  # add  x1, x0, x0
L 08 FFFFF037  # lui  x0, 0xfffff
L 0C 04200513  # addi x10, x0, 0x42
L 10 00150533  # add  x10, x10, x1
L 14 0000006F  # jal  x0, 0
R
E 00000042

/* soc.f */
socPkg.sv
socDecode.sv
socExecute.sv
socResult.sv
socCore.sv
socMemory.sv
socUartDump.sv
soc.sv
socTb.sv
